// ==== rtl/dcache_isa_pkg.sv ====
`default_nettype none

package dcache_isa_pkg;

    // MIPS load/store opcodes served by the cache
    localparam logic [5:0] op_lw = 6'b100011;
    localparam logic [5:0] op_lb = 6'b100000;
    localparam logic [5:0] op_sw = 6'b101011;
    localparam logic [5:0] op_sb = 6'b101000;

    // byte address width on the cpu side
    localparam int unsigned addr_bits = 10;

    // one cached word, seen whole or as four bytes (byte 0 is the lsb)
    typedef union packed {
        logic [31:0]      word;
        logic [3:0][7:0]  bytes;
    } cache_word_u;

    typedef struct packed {
        logic                 valid;
        logic [5:0]           opcode;
        logic [addr_bits-1:0] addr;
        cache_word_u          wdata;
    } cpu_req_t;

    // hit is set when no memory access was needed
    typedef struct packed {
        logic        done;
        logic        hit;
        cache_word_u rdata;
    } cpu_rsp_t;

endpackage

`default_nettype wire

// ==== rtl/dcache_mem_pkg.sv ====
`default_nettype none

package dcache_mem_pkg;

    // address split: tag 9:6, index 5:2, byte offset 1:0
    localparam int unsigned offset_bits = 2;
    localparam int unsigned index_bits  = 4;
    localparam int unsigned tag_bits    = 4;
    localparam int unsigned num_lines   = 16;

    // main memory geometry, one 32-bit word per location
    localparam int unsigned mem_words     = 256;
    localparam int unsigned mem_addr_bits = 8;

    // access latencies in cycles, counted from the rising strobe
    localparam int unsigned mem_rd_latency = 4;
    localparam int unsigned mem_wr_latency = 5;
    localparam int unsigned mem_cnt_bits   = 3;

    localparam int unsigned line_addr_bits = offset_bits + index_bits + tag_bits;

    // write data is not carried here, it comes straight from the array
    typedef struct packed {
        logic                     rd;
        logic                     wr;
        logic [mem_addr_bits-1:0] waddr;
    } mem_req_t;

    function automatic logic [index_bits-1:0] addr_index(input logic [line_addr_bits-1:0] addr);
        return addr[offset_bits +: index_bits];
    endfunction

    function automatic logic [tag_bits-1:0] addr_tag(input logic [line_addr_bits-1:0] addr);
        return addr[offset_bits + index_bits +: tag_bits];
    endfunction

    function automatic logic [mem_addr_bits-1:0] addr_word(input logic [line_addr_bits-1:0] addr);
        return addr[line_addr_bits-1:offset_bits];
    endfunction

endpackage

`default_nettype wire

// ==== rtl/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
    import dcache_isa_pkg::*;
    import dcache_mem_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst_b,
    input  wire cpu_req_t            cpu_req,
    input  wire                      hit,
    input  wire                      dirty,
    input  wire [mem_addr_bits-1:0]  victim_addr,
    input  wire                      mem_ack,
    output mem_req_t                 mem_req,
    output logic                     array_we,
    output logic                     fill_sel,
    output logic                     clear_dirty,
    output logic                     done,
    output logic                     served_hit
);

    typedef enum logic [1:0] {
        st_idle,
        st_write_back,
        st_fill,
        st_respond
    } state_t;

    state_t state_q;
    state_t state_nx;
    logic   missed_q;
    logic   is_store;
    logic   req_hit;

    assign is_store = (cpu_req.opcode == op_sw) || (cpu_req.opcode == op_sb);

    // a valid request that finds its line in idle
    assign req_hit = (state_q == st_idle) && cpu_req.valid && hit;

    always_comb begin
        state_nx = state_q;
        case (state_q)
            st_idle: begin
                if (cpu_req.valid) begin
                    if (hit) begin
                        state_nx = st_respond;
                    end else if (dirty) begin
                        state_nx = st_write_back;
                    end else begin
                        state_nx = st_fill;
                    end
                end
            end
            st_write_back: begin
                // victim is safe in memory, now fetch the requested word
                if (mem_ack) begin
                    state_nx = st_fill;
                end
            end
            st_fill: begin
                // line is written at this edge, the request then hits in idle
                if (mem_ack) begin
                    state_nx = st_idle;
                end
            end
            st_respond: begin
                state_nx = st_idle;
            end
            default: begin
                state_nx = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state_q  <= st_idle;
            missed_q <= 1'b0;
        end else begin
            state_q <= state_nx;
            if (state_q == st_respond) begin
                missed_q <= 1'b0;
            end else if ((state_q == st_idle) && cpu_req.valid && !hit) begin
                missed_q <= 1'b1;
            end
        end
    end

    // store data goes in on a hit, memory data at the end of a fill
    assign array_we    = (req_hit && is_store) || ((state_q == st_fill) && mem_ack);
    assign fill_sel    = (state_q == st_fill);
    assign clear_dirty = (state_q == st_write_back) && mem_ack;

    // strobes stay high for the whole access
    assign mem_req.rd    = (state_q == st_fill);
    assign mem_req.wr    = (state_q == st_write_back);
    assign mem_req.waddr = (state_q == st_write_back) ? victim_addr : addr_word(cpu_req.addr);

    assign done       = (state_q == st_respond);
    assign served_hit = !missed_q;

endmodule

`default_nettype wire

// ==== rtl/dcache_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_array
    import dcache_isa_pkg::*;
    import dcache_mem_pkg::*;
(
    input  wire                      clk,
    input  wire                      rst_b,
    input  wire cpu_req_t            cpu_req,
    input  wire                      array_we,
    input  wire                      fill_sel,
    input  wire                      clear_dirty,
    input  wire [31:0]               mem_rdata,
    output logic                     hit,
    output logic                     dirty,
    output logic [mem_addr_bits-1:0] victim_addr,
    output logic [31:0]              victim_data,
    output cache_word_u              rdata
);

    logic [num_lines-1:0] valid_q;
    logic [num_lines-1:0] dirty_q;
    logic [tag_bits-1:0]  tag_q [num_lines];
    cache_word_u          data_q [num_lines];

    logic [index_bits-1:0]  idx;
    logic [tag_bits-1:0]    req_tag;
    logic [offset_bits-1:0] off;
    cache_word_u            line;
    cache_word_u            merged;
    logic [7:0]             sel_byte;

    assign idx     = addr_index(cpu_req.addr);
    assign req_tag = addr_tag(cpu_req.addr);
    assign off     = cpu_req.addr[offset_bits-1:0];
    assign line    = data_q[idx];

    assign hit         = valid_q[idx] && (tag_q[idx] == req_tag);
    assign dirty       = valid_q[idx] && dirty_q[idx];
    assign victim_addr = {tag_q[idx], idx};
    assign victim_data = line.word;

    // new line contents for a fill, a byte store or a word store
    always_comb begin
        merged = line;
        if (fill_sel) begin
            merged.word = mem_rdata;
        end else if (cpu_req.opcode == op_sb) begin
            merged.bytes[off] = cpu_req.wdata.bytes[0];
        end else begin
            merged.word = cpu_req.wdata.word;
        end
    end

    always_ff @(posedge clk) begin
        if (array_we) begin
            data_q[idx] <= merged;
            if (fill_sel) begin
                tag_q[idx] <= req_tag;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (array_we) begin
            valid_q[idx] <= 1'b1;
            // fresh from memory is clean, any store makes it dirty
            dirty_q[idx] <= !fill_sel;
        end else if (clear_dirty) begin
            dirty_q[idx] <= 1'b0;
        end
    end

    assign sel_byte = line.bytes[off];

    // LB is sign-extended, everything else returns the whole word
    always_comb begin
        if (cpu_req.opcode == op_lb) begin
            rdata.word = {{24{sel_byte[7]}}, sel_byte};
        end else begin
            rdata = line;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/main_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_mem
    import dcache_mem_pkg::*;
(
    input  wire           clk,
    input  wire           rst_b,
    input  wire mem_req_t mem_req,
    input  wire [31:0]    victim_data,
    output logic [31:0]   mem_rdata,
    output logic          mem_ack
);

    logic [31:0]             mem_q [mem_words];
    logic [mem_cnt_bits-1:0] cnt_q;
    logic [mem_cnt_bits-1:0] cnt_last;
    logic                    active;
    logic                    expire;

    // every byte of word k starts out as the low byte of k
    initial begin
        for (int k = 0; k < mem_words; k++) begin
            mem_q[k] = {4{8'(k)}};
        end
    end

    assign cnt_last = mem_req.wr ? mem_cnt_bits'(mem_wr_latency - 1)
                                 : mem_cnt_bits'(mem_rd_latency - 1);

    // the ack cycle itself does not count, so a back-to-back access restarts at zero
    assign active = (mem_req.rd || mem_req.wr) && !mem_ack;
    assign expire = active && (cnt_q == cnt_last);

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            cnt_q   <= '0;
            mem_ack <= 1'b0;
        end else begin
            mem_ack <= expire;
            if (active && !expire) begin
                cnt_q <= cnt_q + 1'b1;
            end else begin
                cnt_q <= '0;
            end
        end
    end

    always @(posedge clk) begin
        if (expire && mem_req.wr) begin
            mem_q[mem_req.waddr] <= victim_data;
        end
    end

    always_ff @(posedge clk) begin
        if (expire && mem_req.rd) begin
            mem_rdata <= mem_q[mem_req.waddr];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import dcache_isa_pkg::*;
    import dcache_mem_pkg::*;
(
    input  wire           clk,
    input  wire           rst_b,
    input  wire cpu_req_t cpu_req,
    output cpu_rsp_t      cpu_rsp
);

    mem_req_t                 mem_req;
    logic                     hit;
    logic                     dirty;
    logic                     array_we;
    logic                     fill_sel;
    logic                     clear_dirty;
    logic                     mem_ack;
    logic                     done;
    logic                     served_hit;
    logic [mem_addr_bits-1:0] victim_addr;
    logic [31:0]              victim_data;
    logic [31:0]              mem_rdata;
    cache_word_u              rdata;

    dcache_ctrl u_dcache_ctrl (
        .clk         (clk),
        .rst_b       (rst_b),
        .cpu_req     (cpu_req),
        .hit         (hit),
        .dirty       (dirty),
        .victim_addr (victim_addr),
        .mem_ack     (mem_ack),
        .mem_req     (mem_req),
        .array_we    (array_we),
        .fill_sel    (fill_sel),
        .clear_dirty (clear_dirty),
        .done        (done),
        .served_hit  (served_hit)
    );

    dcache_array u_dcache_array (
        .clk         (clk),
        .rst_b       (rst_b),
        .cpu_req     (cpu_req),
        .array_we    (array_we),
        .fill_sel    (fill_sel),
        .clear_dirty (clear_dirty),
        .mem_rdata   (mem_rdata),
        .hit         (hit),
        .dirty       (dirty),
        .victim_addr (victim_addr),
        .victim_data (victim_data),
        .rdata       (rdata)
    );

    main_mem u_main_mem (
        .clk         (clk),
        .rst_b       (rst_b),
        .mem_req     (mem_req),
        .victim_data (victim_data),
        .mem_rdata   (mem_rdata),
        .mem_ack     (mem_ack)
    );

    assign cpu_rsp.done  = done;
    assign cpu_rsp.hit   = served_hit;
    assign cpu_rsp.rdata = rdata;

endmodule

`default_nettype wire

// ==== verif/tb_dcache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
    import dcache_isa_pkg::*;
();

    localparam int max_cases       = 64;
    localparam int fields_per_case = 5;
    localparam int timeout_cycles  = 50;
    localparam int stim_delay      = 2;
    localparam logic [31:0] end_marker = 32'h0000_00ff;

    logic     clk;
    logic     rst_b;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;

    // five hex fields per case: opcode, addr, store data, expected rdata, expected hit
    logic [31:0] case_mem [max_cases*fields_per_case];

    int   word_errors;
    int   hit_errors;
    int   pulse_errors;
    int   timeout_errors;
    int   load_errors;
    int   num_cases;
    logic timed_out;

    dcache_top u_dcache_top (
        .clk     (clk),
        .rst_b   (rst_b),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic int count_cases();
        int n;
        n = 0;
        while (n < max_cases && !$isunknown(case_mem[n*fields_per_case])
               && case_mem[n*fields_per_case] != end_marker) begin
            n++;
        end
        return n;
    endfunction

    task automatic check_word(input int idx, input cache_word_u got, input cache_word_u exp);
        if (got.word !== exp.word) begin
            word_errors++;
            $display("[ERROR] %0t: case %0d rdata %h, expected %h",
                     $time, idx, got.word, exp.word);
        end
    endtask

    task automatic check_hit(input int idx, input logic got, input logic exp);
        if (got !== exp) begin
            hit_errors++;
            $display("[ERROR] %0t: case %0d hit %b, expected %b", $time, idx, got, exp);
        end
    endtask

    // present one request, wait for done, then drop valid for the next edge
    task automatic run_case(input int idx);
        int          base;
        int          cycles;
        logic        seen;
        cpu_rsp_t    rsp;
        cache_word_u exp_word;
        base               = idx * fields_per_case;
        cpu_req.opcode     = case_mem[base][5:0];
        cpu_req.addr       = case_mem[base+1][9:0];
        cpu_req.wdata.word = case_mem[base+2];
        cpu_req.valid      = 1'b1;
        exp_word.word      = case_mem[base+3];
        seen               = 1'b0;
        cycles             = 0;
        rsp                = '0;
        // sample in mid cycle where the response is settled
        while (!seen && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
            if (cpu_rsp.done) begin
                seen = 1'b1;
                rsp  = cpu_rsp;
            end
        end
        if (seen) begin
            check_word(idx, rsp.rdata, exp_word);
            check_hit(idx, rsp.hit, case_mem[base+4][0]);
        end else begin
            timeout_errors++;
            timed_out = 1'b1;
            $display("case %0d: done never arrived within %0d cycles", idx, timeout_cycles);
        end
        @(posedge clk);
        #stim_delay;
        cpu_req.valid = 1'b0;
        // done is a single-cycle pulse, so it is gone one cycle later
        if (seen) begin
            @(negedge clk);
            if (cpu_rsp.done) begin
                pulse_errors++;
                $display("case %0d: done stayed high for more than one cycle", idx);
            end
        end
    endtask

    initial begin
        int gap;
        word_errors    = 0;
        hit_errors     = 0;
        pulse_errors   = 0;
        timeout_errors = 0;
        load_errors    = 0;
        timed_out      = 1'b0;
        cpu_req        = '0;
        rst_b          = 1'b0;
        void'($urandom(32'h0087bab0));

        $readmemh("verif/dcache_cases.txt", case_mem);
        num_cases = count_cases();
        if (num_cases == 0) begin
            load_errors++;
            $display("no cases could be read from verif/dcache_cases.txt");
        end

        repeat (2) @(posedge clk);
        #stim_delay;
        rst_b = 1'b1;

        for (int i = 0; i < num_cases && !timed_out; i++) begin
            // idle gap of 1 to 3 cycles between requests
            gap = 1 + int'($urandom % 3);
            repeat (gap) @(posedge clk);
            #stim_delay;
            run_case(i);
        end

        $display("cases %0d, errors: word %0d, hit %0d, pulse %0d, timeout %0d, load %0d",
                 num_cases, word_errors, hit_errors, pulse_errors, timeout_errors,
                 load_errors);
        if (word_errors + hit_errors + pulse_errors + timeout_errors + load_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/dcache_cases.txt ====
// opcode  addr  store_data  exp_rdata  exp_hit   (all hex)
// opcodes: 23 lw, 20 lb, 2b sw, 28 sb; a line with opcode ff ends the list
// cold load misses, the repeat hits
23 010 00000000 04040404 0
23 010 00000000 04040404 1
20 011 00000000 00000004 1
// byte 0x85 sign-extends at every offset
20 214 00000000 ffffff85 0
20 215 00000000 ffffff85 1
20 216 00000000 ffffff85 1
20 217 00000000 ffffff85 1
// word store on a cold line, read back as word and bytes
2b 024 8a7b6c5d 8a7b6c5d 0
23 024 00000000 8a7b6c5d 1
20 024 00000000 0000005d 1
20 025 00000000 0000006c 1
20 026 00000000 0000007b 1
20 027 00000000 ffffff8a 1
// byte store touches one byte only
28 026 000000e1 8ae16c5d 1
23 024 00000000 8ae16c5d 1
// other tag on index 9 evicts the dirty line, then reload it from memory
23 0e4 00000000 39393939 0
23 024 00000000 8ae16c5d 0
// clean conflicts return preset contents
23 0e4 00000000 39393939 0
23 150 00000000 54545454 0
23 010 00000000 04040404 0
// byte store miss, then store and load misses over dirty victims
28 3fd 00000022 ffff22ff 0
2b 03c 12345678 12345678 0
23 3fc 00000000 ffff22ff 0
20 3fd 00000000 00000022 1
23 03c 00000000 12345678 0
ff 000 00000000 00000000 0

// ==== flist.f ====
rtl/dcache_isa_pkg.sv
rtl/dcache_mem_pkg.sv
rtl/dcache_ctrl.sv
rtl/dcache_array.sv
rtl/main_mem.sv
rtl/dcache_top.sv
verif/tb_dcache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_dcache -o sim_dcache

output="$(./obj_dir/sim_dcache)"
echo "$output"

if grep -qx "TEST PASS" <<< "$output"; then
    exit 0
else
    exit 1
fi
